//--- lsu_core.f
hdl/lsu_pkg.sv
hdl/store_align.sv
hdl/data_ram.sv
hdl/load_extract.sv
hdl/lsu_core.sv
sim/lsu_core_checker.sv
sim/lsu_core_tb.sv

//--- sim/lsu_core_tb.sv
`timescale 1ns/1ps

module lsu_core_tb;
    import lsu_pkg::*;

    localparam int ADDR_W = 12;
    localparam int DWORDS = 2 ** (ADDR_W - 3);

    logic              clk = 1'b0;
    logic              rst_n;
    logic              req;
    logic [op_w-1:0]   op;
    logic [ADDR_W-1:0] addr;
    logic [63:0]       wdata;
    logic              rsp_valid;
    logic              rsp_fault;
    logic [63:0]       rdata;
    int                errors;
    int                pending;
    int                phase_base = 0;
    int                phases = 0;
    int                timeouts = 0;

    always #2 clk = ~clk;

    lsu_core #(.ADDR_W(ADDR_W)) dut0 (
        .clk(clk), .rst_n(rst_n), .req(req), .op(op), .addr(addr), .wdata(wdata),
        .rsp_valid(rsp_valid), .rsp_fault(rsp_fault), .rdata(rdata)
    );

    lsu_core_checker #(.ADDR_W(ADDR_W)) chk0 (
        .clk(clk), .rst_n(rst_n), .req(req), .op(op), .addr(addr), .wdata(wdata),
        .rsp_valid(rsp_valid), .rsp_fault(rsp_fault), .rdata(rdata),
        .errors(errors), .pending(pending)
    );

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    function automatic logic [63:0] rand_dword();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [ADDR_W-1:0] aligned_addr(input logic [1:0] size);
        logic [2:0] lo;
        lo = 3'($urandom_range(7)) & ~3'((1 << size) - 1);
        return {(ADDR_W-3)'($urandom_range(DWORDS - 1)), lo};
    endfunction

    // Setting bit 0 breaks the alignment of any half, word or double access
    function automatic logic [ADDR_W-1:0] misaligned_addr(input logic [1:0] size);
        logic [ADDR_W-1:0] a;
        a = aligned_addr(2'd0);
        if ((a[2:0] & 3'((1 << size) - 1)) == 3'd0) begin
            a[0] = 1'b1;
        end
        return a;
    endfunction

    function automatic logic [op_w-1:0] store_op(input logic [1:0] size);
        return {2'b10, size};
    endfunction

    function automatic logic [op_w-1:0] load_op(input logic uns, input logic [1:0] size);
        return {1'b0, uns & (size != 2'd3), size};
    endfunction

    task automatic issue(input logic [op_w-1:0] o, input logic [ADDR_W-1:0] a,
                         input logic [63:0] d);
        @(posedge clk);
        req   <= 1'b1;
        op    <= o;
        addr  <= a;
        wdata <= d;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            req <= 1'b0;
        end
    endtask

    task automatic finish_phase(input string name);
        int waited;
        idle(1);
        waited = 0;
        @(negedge clk);
        while (pending != 0 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            timeouts++;
            $display("Phase %s timed out with %0d responses still pending", name, pending);
        end
        phases++;
        $display("Phase %s done, %0d errors", name, errors - phase_base);
        phase_base = errors;
    endtask

    initial begin
        logic [ADDR_W-1:0] a;
        logic [1:0]        size;
        rst_n = 1'b0;
        req   = 1'b0;
        op    = op_lb;
        addr  = '0;
        wdata = '0;
        void'($urandom(32'h3f4b7518));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // The checker flags any response during the idle cycles
        idle(10);
        a = aligned_addr(2'd3);
        issue(op_sd, a, rand_dword());
        issue(op_ld, a, '0);
        finish_phase("reset_and_first_load");

        for (int i = 0; i < DWORDS; i++) begin
            issue(op_sd, ADDR_W'(i * 8), rand_dword());
        end
        finish_phase("memory_init");

        for (int i = 0; i < 100; i++) begin
            size = 2'($urandom_range(2));
            a = aligned_addr(size);
            issue(store_op(size), a, rand_dword());
            issue(op_ld, {a[ADDR_W-1:3], 3'b000}, '0);
        end
        finish_phase("partial_stores");

        for (int i = 0; i < 150; i++) begin
            size = 2'($urandom_range(2));
            a = aligned_addr(size);
            if ($urandom_range(1) == 1) begin
                issue(op_sd, {a[ADDR_W-1:3], 3'b000}, rand_dword() | 64'h8000_8080_8000_8080);
            end
            issue(load_op(1'($urandom_range(1)), size), a, '0);
        end
        finish_phase("extension_loads");

        for (int blk = 0; blk < 8; blk++) begin
            a = aligned_addr(2'd3);
            for (int k = 0; k < 16; k++) begin
                size = 2'($urandom_range(3));
                a[2:0] = 3'(aligned_addr(size));
                if ($urandom_range(1) == 1) begin
                    issue(store_op(size), a, rand_dword());
                end else begin
                    issue(load_op(1'($urandom_range(1)), size), a, '0);
                end
            end
        end
        finish_phase("back_to_back");

        for (int i = 0; i < 60; i++) begin
            size = 2'($urandom_range(3, 1));
            a = misaligned_addr(size);
            if ($urandom_range(1) == 1) begin
                issue(store_op(size), a, rand_dword());
                issue(op_ld, {a[ADDR_W-1:3], 3'b000}, '0);
            end else begin
                issue(load_op(1'($urandom_range(1)), size), a, '0);
            end
        end
        finish_phase("misaligned");

        $display("Totals: %0d phases, %0d errors, %0d timeouts", phases, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sim/lsu_core_checker.sv
`timescale 1ns/1ps

module lsu_core_checker #(
    parameter int ADDR_W = 12
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  logic [lsu_pkg::op_w-1:0] op,
    input  logic [ADDR_W-1:0]        addr,
    input  logic [63:0]              wdata,
    input  logic                     rsp_valid,
    input  logic                     rsp_fault,
    input  logic [63:0]              rdata,
    output int                       errors,
    output int                       pending
);
    logic [63:0] ref_mem [2 ** (ADDR_W - 3)];
    int          due_q [$];
    logic        fault_q [$];
    logic [63:0] data_q [$];
    int          cycle;
    int          nbytes;
    logic [2:0]  lo;
    logic [63:0] part;
    logic [63:0] mask;

    initial errors = 0;

    task automatic expect_rsp(input logic f, input logic [63:0] d);
        due_q.push_back(cycle + 2);
        fault_q.push_back(f);
        data_q.push_back(d);
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle = 0;
            due_q.delete();
            fault_q.delete();
            data_q.delete();
        end else begin
            cycle++;
            // ------------------------------
            // Response check for this cycle
            // ------------------------------
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                if (rsp_valid !== 1'b1) begin
                    errors++;
                    $display("Missing response at %0t, one was due in this cycle", $time);
                end else if (rsp_fault !== fault_q[0] || rdata !== data_q[0]) begin
                    errors++;
                    $display("mismatch at %0t: expected fault %0b rdata %h, got fault %0b rdata %h",
                             $time, fault_q[0], data_q[0], rsp_fault, rdata);
                end
                void'(due_q.pop_front());
                void'(fault_q.pop_front());
                void'(data_q.pop_front());
            end else if (rsp_valid !== 1'b0) begin
                errors++;
                $display("Unexpected response at %0t, no request was due", $time);
            end else if (rsp_fault !== 1'b0 || rdata !== 64'd0) begin
                errors++;
                $display("mismatch at %0t: idle outputs expected zero, got fault %0b rdata %h",
                         $time, rsp_fault, rdata);
            end
            // ------------------------------
            // Reference model of the request
            // ------------------------------
            if (req) begin
                nbytes = 1 << op[1:0];
                lo     = addr[2:0];
                part   = ref_mem[addr[ADDR_W-1:3]] >> (8 * lo);
                mask   = (nbytes == 8) ? '1 : (64'd1 << (8 * nbytes)) - 64'd1;
                if (lo % nbytes != 0) begin
                    expect_rsp(1'b1, 64'd0);
                end else if (op[3]) begin
                    for (int i = 0; i < nbytes; i++) begin
                        ref_mem[addr[ADDR_W-1:3]][8*(lo+i) +: 8] = wdata[8*i +: 8];
                    end
                end else begin
                    part = part & mask;
                    // Signed loads copy the top bit of the part upward
                    if (!op[2] && part[8*nbytes-1]) begin
                        part = part | ~mask;
                    end
                    expect_rsp(1'b0, part);
                end
            end
        end
        pending = due_q.size();
    end

endmodule

//--- hdl/lsu_core.sv
`timescale 1ns/1ps

module lsu_core #(
    parameter int ADDR_W = 12
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    input  logic [lsu_pkg::op_w-1:0] op,
    input  logic [ADDR_W-1:0]        addr,
    input  logic [lsu_pkg::xlen-1:0] wdata,
    output logic                     rsp_valid,
    output logic                     rsp_fault,
    output logic [lsu_pkg::xlen-1:0] rdata
);
    import lsu_pkg::*;

    logic [7:0]      byteenable;
    logic [xlen-1:0] lanes;
    logic            wen;
    logic            ren;
    logic            fault;
    logic            respond;
    lsu_word_u       rword;

    // ------------------------------
    // Request decode
    // ------------------------------
    store_align u_align (
        .op         (op),
        .addr_lo    (addr[2:0]),
        .wdata      (wdata),
        .req        (req),
        .byteenable (byteenable),
        .lanes      (lanes),
        .wen        (wen),
        .ren        (ren),
        .fault      (fault),
        .respond    (respond)
    );

    // ------------------------------
    // Data memory
    // ------------------------------
    data_ram #(
        .ADDR_W (ADDR_W)
    ) u_ram (
        .clk        (clk),
        .wen        (wen),
        .ren        (ren),
        .index      (addr[ADDR_W-1:3]),
        .byteenable (byteenable),
        .lanes      (lanes),
        .rword      (rword)
    );

    // ------------------------------
    // Load result and response
    // ------------------------------
    load_extract u_extract (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture    (respond),
        .op         (op),
        .byteenable (byteenable),
        .fault      (fault),
        .rword      (rword),
        .rsp_valid  (rsp_valid),
        .rsp_fault  (rsp_fault),
        .rdata      (rdata)
    );

endmodule

//--- hdl/load_extract.sv
`timescale 1ns/1ps

module load_extract (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     capture,
    input  logic [lsu_pkg::op_w-1:0] op,
    input  logic [7:0]               byteenable,
    input  logic                     fault,
    input  lsu_pkg::lsu_word_u       rword,
    output logic                     rsp_valid,
    output logic                     rsp_fault,
    output logic [lsu_pkg::xlen-1:0] rdata
);
    import lsu_pkg::*;

    logic            pend_q;
    logic [op_w-1:0] op_q;
    logic [7:0]      be_q;
    logic            fault_q;

    logic [2:0]      lo;
    logic [7:0]      sel_b;
    logic [15:0]     sel_h;
    logic [31:0]     sel_w;
    logic [xlen-1:0] ext;

    // ------------------------------
    // Stage one, beside the memory read
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            op_q    <= op;
            be_q    <= byteenable;
            fault_q <= fault;
        end
    end

    // ------------------------------
    // Stage two, select and extend
    // ------------------------------

    // Lowest enabled byte gives the offset of the addressed part
    always_comb begin
        lo = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (be_q[i]) begin
                lo = 3'(i);
            end
        end
    end

    assign sel_b = rword.b[lo];
    assign sel_h = rword.h[lo[2:1]];
    assign sel_w = rword.w[lo[2]];

    always_comb begin
        case (op_q)
            op_lb:   ext = {{56{sel_b[7]}}, sel_b};
            op_lh:   ext = {{48{sel_h[15]}}, sel_h};
            op_lw:   ext = {{32{sel_w[31]}}, sel_w};
            op_ld:   ext = rword.d;
            op_lbu:  ext = {56'b0, sel_b};
            op_lhu:  ext = {48'b0, sel_h};
            op_lwu:  ext = {32'b0, sel_w};
            default: ext = '0;
        endcase
    end

    // Response register, rdata is forced to zero on a fault
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_fault <= 1'b0;
            rdata     <= '0;
        end else begin
            rsp_valid <= pend_q;
            rsp_fault <= pend_q & fault_q;
            if (pend_q && !fault_q) begin
                rdata <= ext;
            end else begin
                rdata <= '0;
            end
        end
    end

endmodule

//--- hdl/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int ADDR_W = 12
) (
    input  logic                     clk,
    input  logic                     wen,
    input  logic                     ren,
    input  logic [ADDR_W-4:0]        index,
    input  logic [7:0]               byteenable,
    input  logic [lsu_pkg::xlen-1:0] lanes,
    output lsu_pkg::lsu_word_u       rword
);
    import lsu_pkg::*;

    localparam int DEPTH = 2 ** (ADDR_W - 3);

    lsu_word_u mem [DEPTH];

    // Byte-lane write
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < 8; i++) begin
                if (byteenable[i]) begin
                    mem[index].b[i] <= lanes[8*i +: 8];
                end
            end
        end
    end

    // Registered read, holds its value between loads
    always_ff @(posedge clk) begin
        if (ren) begin
            rword <= mem[index];
        end
    end

endmodule

//--- hdl/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  logic [lsu_pkg::op_w-1:0] op,
    input  logic [2:0]               addr_lo,
    input  logic [lsu_pkg::xlen-1:0] wdata,
    input  logic                     req,
    output logic [7:0]               byteenable,
    output logic [lsu_pkg::xlen-1:0] lanes,
    output logic                     wen,
    output logic                     ren,
    output logic                     fault,
    output logic                     respond
);
    import lsu_pkg::*;

    logic [1:0] size;
    logic       is_load;
    logic [7:0] be_base;

    assign size    = op[1:0];
    assign is_load = ~op[3];

    // ------------------------------
    // Alignment check
    // ------------------------------
    always_comb begin
        case (size)
            sz_byte: fault = 1'b0;
            sz_half: fault = addr_lo[0];
            sz_word: fault = |addr_lo[1:0];
            default: fault = |addr_lo;
        endcase
    end

    // ------------------------------
    // Byte enables and store lanes
    // ------------------------------
    always_comb begin
        case (size)
            sz_byte: begin
                be_base = 8'h01;
                lanes   = {8{wdata[7:0]}};
            end
            sz_half: begin
                be_base = 8'h03;
                lanes   = {4{wdata[15:0]}};
            end
            sz_word: begin
                be_base = 8'h0f;
                lanes   = {2{wdata[31:0]}};
            end
            default: begin
                be_base = 8'hff;
                lanes   = wdata;
            end
        endcase
    end

    // Shifted mask only matters for aligned accesses, a misaligned one faults anyway
    assign byteenable = be_base << addr_lo;

    // Faulted requests never reach the memory
    assign wen = req & ~is_load & ~fault;
    assign ren = req & is_load & ~fault;

    // Loads and faulted requests of either kind produce a response
    assign respond = req & (is_load | fault);

endmodule

//--- hdl/lsu_pkg.sv
package lsu_pkg;

    // Operation code fields
    // Bit 3 set marks a store, bit 2 an unsigned load, bits 1:0 the size
    localparam int op_w = 4;
    localparam int xlen = 64;

    localparam logic [1:0] sz_byte = 2'd0;
    localparam logic [1:0] sz_half = 2'd1;
    localparam logic [1:0] sz_word = 2'd2;
    localparam logic [1:0] sz_dbl  = 2'd3;

    // ------------------------------
    // Loads
    // ------------------------------
    localparam logic [op_w-1:0] op_lb  = 4'b0000;
    localparam logic [op_w-1:0] op_lh  = 4'b0001;
    localparam logic [op_w-1:0] op_lw  = 4'b0010;
    localparam logic [op_w-1:0] op_ld  = 4'b0011;
    localparam logic [op_w-1:0] op_lbu = 4'b0100;
    localparam logic [op_w-1:0] op_lhu = 4'b0101;
    localparam logic [op_w-1:0] op_lwu = 4'b0110;

    // ------------------------------
    // Stores
    // ------------------------------
    localparam logic [op_w-1:0] op_sb  = 4'b1000;
    localparam logic [op_w-1:0] op_sh  = 4'b1001;
    localparam logic [op_w-1:0] op_sw  = 4'b1010;
    localparam logic [op_w-1:0] op_sd  = 4'b1011;

    // One memory doubleword, seen as bytes, halves, words or the whole word
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } lsu_word_u;

endpackage
